//--- include/dsp_tx_macros.svh
//------------------------------------------------------------
// frontend width must be 16 or more, samples sit in the top bits
// settings addresses are shared by all blocks on one bus
//------------------------------------------------------------
`ifndef DSP_TX_MACROS_SVH
`define DSP_TX_MACROS_SVH

// frontend bus width, default for every WIDTH parameter
`define DSP_TX_FE_WIDTH 24

// settings bus addresses
`define SR_DUC_RATE 8'd0
`define SR_DUC_ROT 8'd1
`define SR_CUSTOM_GAIN 8'd2

// interpolation rate after reset, 0 also behaves as 1
`define DUC_RATE_RESET 8'd1

// rotation after reset, no turn
`define DUC_ROT_RESET 2'd0

// gain is unsigned Q2.14
`define GAIN_FRAC_BITS 14

// 1.0 in Q2.14
`define CUSTOM_GAIN_UNITY 16'd16384

`endif

//--- verilog/dsp_tx_pkg.sv
//------------------------------------------------------------
// types shared by the tx core, its slot and its DUC
// samples are packed {I,Q}, I in the upper half
//------------------------------------------------------------
`default_nettype none

package dsp_tx_pkg;

    // packed baseband sample {I16,Q16}
    typedef logic [31:0] sample_t;

    // one signed sample component
    typedef logic signed [15:0] iq_comp_t;

    // settings bus fields
    typedef logic [7:0] set_addr_t;
    typedef logic [31:0] set_data_t;

    // interpolation rate, 0 is treated as 1
    typedef logic [7:0] interp_rate_t;

    // unsigned Q2.14 gain, max just under 4.0
    typedef logic [15:0] gain_t;

    // rotation in quarter turns
    typedef logic [1:0] rot_t;

endpackage

`default_nettype wire

//--- verilog/custom_dsp_tx.sv
//------------------------------------------------------------
// user DSP slot around the DUC, pre-DUC gain is the only
// processing, frontend and strobe paths pass straight through
// gain product is saturated to the signed 16-bit range
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module custom_dsp_tx
    import dsp_tx_pkg::*;
#(
    // frontend bus width
    parameter int WIDTH = `DSP_TX_FE_WIDTH
) (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             enable,
    // settings bus
    input  wire logic             set_stb,
    input  wire set_addr_t        set_addr,
    input  wire set_data_t        set_data,
    // full rate to the TX frontend
    output      logic [WIDTH-1:0] frontend_i,
    output      logic [WIDTH-1:0] frontend_q,
    // full rate from the DUC
    input  wire logic [WIDTH-1:0] duc_out_i,
    input  wire logic [WIDTH-1:0] duc_out_q,
    // strobed samples towards the DUC
    output      sample_t          duc_in_sample,
    input  wire logic             duc_in_strobe,
    // strobed baseband samples from the source
    input  wire sample_t          bb_sample,
    output      logic             bb_strobe
);

    gain_t    gain_reg;
    iq_comp_t bb_i;
    iq_comp_t bb_q;

    // component times Q2.14 gain, clipped to 16 bits
    function automatic iq_comp_t apply_gain(input iq_comp_t x, input gain_t g);
        logic signed [32:0] prod;
        logic signed [32:0] scaled;
        prod = x * $signed({1'b0, g});
        // arithmetic shift floors towards minus infinity
        scaled = prod >>> `GAIN_FRAC_BITS;
        if (scaled > 33'sd32767) begin
            return 16'sh7FFF;
        end else if (scaled < -33'sd32768) begin
            return 16'sh8000;
        end
        return iq_comp_t'(scaled);
    endfunction

    // gain register, low half of the settings word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            gain_reg <= `CUSTOM_GAIN_UNITY;
        end else if (set_stb && set_addr == `SR_CUSTOM_GAIN) begin
            gain_reg <= set_data[15:0];
        end
    end

    assign bb_i = bb_sample[31:16];
    assign bb_q = bb_sample[15:0];

    // combinational, sample is taken by the DUC on its own strobe
    assign duc_in_sample = {apply_gain(bb_i, gain_reg), apply_gain(bb_q, gain_reg)};

    // consumer strobe is the back-pressure towards the source
    assign bb_strobe = duc_in_strobe && enable;

    // no post-DUC processing
    assign frontend_i = duc_out_i;
    assign frontend_q = duc_out_q;

endmodule

`default_nettype wire

//--- verilog/duc_chain.sv
//------------------------------------------------------------
// zero-order-hold interpolator with quarter-turn rotation
// strobe starts one cycle after enable, never waits on the source
// WIDTH must be 16 or more, low output bits are zero
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module duc_chain
    import dsp_tx_pkg::*;
#(
    // frontend bus width
    parameter int WIDTH = `DSP_TX_FE_WIDTH
) (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             enable,
    // settings bus
    input  wire logic             set_stb,
    input  wire set_addr_t        set_addr,
    input  wire set_data_t        set_data,
    // strobed input sample and its strobe
    input  wire sample_t          duc_in_sample,
    output      logic             duc_in_strobe,
    // full rate output, held between strobes
    output      logic [WIDTH-1:0] duc_out_i,
    output      logic [WIDTH-1:0] duc_out_q
);

    interp_rate_t rate_reg;
    interp_rate_t rate_eff;
    rot_t         rot_reg;
    interp_rate_t cnt;
    logic         running;
    iq_comp_t     in_i;
    iq_comp_t     in_q;
    iq_comp_t     rot_i;
    iq_comp_t     rot_q;

    // negate with the one overflow case clipped
    function automatic iq_comp_t neg_sat(input iq_comp_t x);
        if (x == 16'sh8000) begin
            return 16'sh7FFF;
        end
        return -x;
    endfunction

    // sign-extend then push the component to the top 16 bits
    function automatic logic [WIDTH-1:0] widen(input iq_comp_t x);
        logic signed [WIDTH-1:0] ext;
        ext = WIDTH'(x);
        return ext << (WIDTH - 16);
    endfunction

    // rate and rotation registers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rate_reg <= `DUC_RATE_RESET;
            rot_reg  <= `DUC_ROT_RESET;
        end else if (set_stb) begin
            if (set_addr == `SR_DUC_RATE) begin
                rate_reg <= set_data[7:0];
            end
            if (set_addr == `SR_DUC_ROT) begin
                rot_reg <= set_data[1:0];
            end
        end
    end

    assign rate_eff = (rate_reg == '0) ? interp_rate_t'(1) : rate_reg;

    // running goes high at the first edge with enable seen,
    // so the first strobe lands in the following cycle
    assign duc_in_strobe = enable && running && (cnt == '0);

    // down-counter, reloaded on each strobe so a new rate
    // only shows up from the next strobe on
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (!enable) begin
            cnt     <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (duc_in_strobe) begin
                cnt <= rate_eff - interp_rate_t'(1);
            end else if (cnt != '0) begin
                cnt <= cnt - interp_rate_t'(1);
            end
        end
    end

    assign in_i = duc_in_sample[31:16];
    assign in_q = duc_in_sample[15:0];

    // multiply by j^rot
    always_comb begin
        case (rot_reg)
            2'd1: begin
                rot_i = neg_sat(in_q);
                rot_q = in_i;
            end
            2'd2: begin
                rot_i = neg_sat(in_i);
                rot_q = neg_sat(in_q);
            end
            2'd3: begin
                rot_i = in_q;
                rot_q = neg_sat(in_i);
            end
            default: begin
                rot_i = in_i;
                rot_q = in_q;
            end
        endcase
    end

    // zero-order hold, updated only at the end of a strobe cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            duc_out_i <= '0;
            duc_out_q <= '0;
        end else if (duc_in_strobe) begin
            duc_out_i <= widen(rot_i);
            duc_out_q <= widen(rot_q);
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_tx_core.sv
//------------------------------------------------------------
// tx DSP top, custom slot wrapped around the DUC
// source must present the next sample by the next bb_strobe
// settings writes are single-cycle strobes, no handshake
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module dsp_tx_core
    import dsp_tx_pkg::*;
#(
    // frontend bus width
    parameter int WIDTH = `DSP_TX_FE_WIDTH
) (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             enable,
    // settings bus, decoded by both blocks
    input  wire logic             set_stb,
    input  wire set_addr_t        set_addr,
    input  wire set_data_t        set_data,
    // baseband side
    input  wire sample_t          bb_sample,
    output      logic             bb_strobe,
    // frontend side, full rate
    output      logic [WIDTH-1:0] frontend_i,
    output      logic [WIDTH-1:0] frontend_q
);

    // slot to DUC
    sample_t          duc_in_sample;
    // DUC to slot
    logic             duc_in_strobe;
    logic [WIDTH-1:0] duc_out_i;
    logic [WIDTH-1:0] duc_out_q;

    custom_dsp_tx #(
        .WIDTH(WIDTH)
    ) u_custom_dsp_tx (
        .clock        (clock),
        .rst_n        (rst_n),
        .enable       (enable),
        .set_stb      (set_stb),
        .set_addr     (set_addr),
        .set_data     (set_data),
        .frontend_i   (frontend_i),
        .frontend_q   (frontend_q),
        .duc_out_i    (duc_out_i),
        .duc_out_q    (duc_out_q),
        .duc_in_sample(duc_in_sample),
        .duc_in_strobe(duc_in_strobe),
        .bb_sample    (bb_sample),
        .bb_strobe    (bb_strobe)
    );

    duc_chain #(
        .WIDTH(WIDTH)
    ) u_duc_chain (
        .clock        (clock),
        .rst_n        (rst_n),
        .enable       (enable),
        .set_stb      (set_stb),
        .set_addr     (set_addr),
        .set_data     (set_data),
        .duc_in_sample(duc_in_sample),
        .duc_in_strobe(duc_in_strobe),
        .duc_out_i    (duc_out_i),
        .duc_out_q    (duc_out_q)
    );

endmodule

`default_nettype wire

//--- testbench/dsp_tx_checker.sv
//------------------------------------------------------------
// cycle model of the tx core, compares every cycle after reset
// settings are tracked only from the bus ports it watches
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module dsp_tx_checker
    import dsp_tx_pkg::*;
#(
    parameter int WIDTH = `DSP_TX_FE_WIDTH
) (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             enable,
    input  wire logic             set_stb,
    input  wire set_addr_t        set_addr,
    input  wire set_data_t        set_data,
    input  wire sample_t          bb_sample,
    input  wire logic             bb_strobe,
    input  wire logic [WIDTH-1:0] frontend_i,
    input  wire logic [WIDTH-1:0] frontend_q,
    // test bookkeeping from the testbench
    input  wire logic [7:0]       test_num,
    input  wire logic             test_done,
    output      int               error_count,
    output      int               tests_run,
    output      int               tests_failed
);

    gain_t            gain_m;
    rot_t             rot_m;
    interp_rate_t     rate_m;
    // enabled cycles left until the next strobe is due
    int               due;
    logic [WIDTH-1:0] exp_i;
    logic [WIDTH-1:0] exp_q;
    int               test_errors;
    int               test_samples;

    initial begin
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        test_samples = 0;
    end

    // gain in Q2.14, floor of the scaled product, clipped to 16 bits
    function automatic iq_comp_t scale_comp(input iq_comp_t c, input gain_t g);
        longint prod;
        prod = longint'(c) * longint'(g);
        prod = prod >>> 14;
        if (prod > 32767) begin
            prod = 32767;
        end else if (prod < -32768) begin
            prod = -32768;
        end
        return iq_comp_t'(prod);
    endfunction

    // -(-32768) does not fit, clipped to +32767
    function automatic iq_comp_t negate_clip(input iq_comp_t c);
        if (c == -16'sd32768) begin
            return 16'sd32767;
        end
        return -c;
    endfunction

    // component in the top 16 bits, zeros below
    function automatic logic [WIDTH-1:0] place_top(input iq_comp_t c);
        logic [WIDTH-1:0] w;
        w = '0;
        w[WIDTH-1 -: 16] = c;
        return w;
    endfunction

    task automatic value_error(input string name, input logic [WIDTH-1:0] exp_v,
                               input logic [WIDTH-1:0] got_v);
        $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp_v, got_v);
        test_errors++;
        error_count++;
    endtask

    always @(posedge clock) begin : model
        iq_comp_t g_i;
        iq_comp_t g_q;
        iq_comp_t r_i;
        iq_comp_t r_q;
        if (!rst_n) begin
            gain_m = `CUSTOM_GAIN_UNITY;
            rot_m  = 2'd0;
            rate_m = 8'd1;
            due    = 1;
            exp_i  = '0;
            exp_q  = '0;
        end else begin
            // outputs still show the last sample consumed before this edge
            if (frontend_i !== exp_i) begin
                value_error("frontend_i", exp_i, frontend_i);
            end
            if (frontend_q !== exp_q) begin
                value_error("frontend_q", exp_q, frontend_q);
            end
            if (bb_strobe !== (enable && due == 0)) begin
                $display("ERROR at %0t ns: bb_strobe expected %0b got %0b",
                         $time, enable && due == 0, bb_strobe);
                test_errors++;
                error_count++;
            end
            // first strobe one cycle after enable rises, then every R cycles
            if (!enable) begin
                due = 1;
            end else if (bb_strobe === 1'b1) begin
                due = (rate_m == 0) ? 0 : int'(rate_m) - 1;
            end else if (due > 0) begin
                due--;
            end
            if (bb_strobe === 1'b1) begin
                g_i = scale_comp(bb_sample[31:16], gain_m);
                g_q = scale_comp(bb_sample[15:0], gain_m);
                case (rot_m)
                    2'd1: begin
                        r_i = negate_clip(g_q);
                        r_q = g_i;
                    end
                    2'd2: begin
                        r_i = negate_clip(g_i);
                        r_q = negate_clip(g_q);
                    end
                    2'd3: begin
                        r_i = g_q;
                        r_q = negate_clip(g_i);
                    end
                    default: begin
                        r_i = g_i;
                        r_q = g_q;
                    end
                endcase
                exp_i = place_top(r_i);
                exp_q = place_top(r_q);
                test_samples++;
            end
            // writes land after this edge's sample was taken
            if (set_stb) begin
                case (set_addr)
                    `SR_DUC_RATE:    rate_m = set_data[7:0];
                    `SR_DUC_ROT:     rot_m  = set_data[1:0];
                    `SR_CUSTOM_GAIN: gain_m = set_data[15:0];
                    default: ;
                endcase
            end
            if (test_done) begin
                tests_run++;
                if (test_samples == 0) begin
                    $display("test %0d: no sample was consumed", test_num);
                    tests_failed++;
                end else if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %0d: %s, %0d samples, %0d errors", test_num,
                         (test_errors == 0 && test_samples != 0) ? "ok" : "FAILED",
                         test_samples, test_errors);
                test_errors  = 0;
                test_samples = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/dsp_tx_assert.sv
//------------------------------------------------------------
// strobe and hold properties, bound into dsp_tx_core
// rate is tracked from the settings bus, not from the DUC
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module dsp_tx_assert
    import dsp_tx_pkg::*;
#(
    parameter int WIDTH = `DSP_TX_FE_WIDTH
) (
    input wire logic             clock,
    input wire logic             rst_n,
    input wire logic             enable,
    input wire logic             set_stb,
    input wire set_addr_t        set_addr,
    input wire set_data_t        set_data,
    input wire logic             bb_strobe,
    input wire logic [WIDTH-1:0] frontend_i,
    input wire logic [WIDTH-1:0] frontend_q
);

    interp_rate_t rate_seen;
    int           gate_fails = 0;
    int           rate_fails = 0;
    int           hold_fails = 0;
    int           fail_count;

    assign fail_count = gate_fails + rate_fails + hold_fails;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rate_seen <= `DUC_RATE_RESET;
        end else if (set_stb && set_addr == `SR_DUC_RATE) begin
            rate_seen <= set_data[7:0];
        end
    end

    // no consumption while held off
    gate_a: assert property (@(posedge clock) (!rst_n || !enable) |-> !bb_strobe)
        else begin
            gate_fails++;
            $error("bb_strobe seen while disabled or in reset");
        end

    // rate 1 (or 0) keeps the strobe high every enabled cycle
    rate_one_a: assert property (@(posedge clock) disable iff (!rst_n)
        (bb_strobe && rate_seen <= 8'd1) |=> (!enable || bb_strobe))
        else begin
            rate_fails++;
            $error("strobe gap at rate 1");
        end

    // zero-order hold, outputs move only one edge after a strobe
    hold_a: assert property (@(posedge clock) disable iff (!rst_n)
        !$past(bb_strobe) |-> ($stable(frontend_i) && $stable(frontend_q)))
        else begin
            hold_fails++;
            $error("frontend changed without a strobe");
        end

endmodule

bind dsp_tx_core dsp_tx_assert #(.WIDTH(WIDTH)) u_dsp_tx_assert (
    .clock     (clock),
    .rst_n     (rst_n),
    .enable    (enable),
    .set_stb   (set_stb),
    .set_addr  (set_addr),
    .set_data  (set_data),
    .bb_strobe (bb_strobe),
    .frontend_i(frontend_i),
    .frontend_q(frontend_q)
);

`default_nettype wire

//--- testbench/dsp_tx_core_tb.sv
//------------------------------------------------------------
// table driven testbench, settings written with enable low
// inputs change on the falling edge only
//------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "dsp_tx_macros.svh"

module dsp_tx_core_tb
    import dsp_tx_pkg::*;
();

    localparam int WIDTH        = `DSP_TX_FE_WIDTH;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ROWS     = 14;
    // writes, pause, tail and bookkeeping per row, in cycles
    localparam int ROW_SETUP    = 24;
    localparam int SEED         = 97164;
    localparam logic [7:0] NO_PAUSE = 8'hFF;

    // one test: settings, sample count, sample kind, optional pause
    typedef struct packed {
        logic         write_cfg;
        interp_rate_t rate;
        gain_t        gain;
        rot_t         rot;
        logic [7:0]   nsamp;
        logic         corner;
        logic [7:0]   pause_at;
        logic         junk;
    } row_t;

    logic             clock = 1'b0;
    logic             rst_n;
    logic             enable;
    logic             set_stb;
    set_addr_t        set_addr;
    set_data_t        set_data;
    sample_t          bb_sample;
    logic             bb_strobe;
    logic [WIDTH-1:0] frontend_i;
    logic [WIDTH-1:0] frontend_q;
    logic [7:0]       test_num;
    logic             test_done;
    int               error_count;
    int               tests_run;
    int               tests_failed;
    int               assert_fails;
    row_t             rows [NUM_ROWS];
    logic             table_ready = 1'b0;

    always #(PERIOD / 2) clock = ~clock;

    dsp_tx_core #(.WIDTH(WIDTH)) u_dsp_tx_core (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .set_stb   (set_stb),
        .set_addr  (set_addr),
        .set_data  (set_data),
        .bb_sample (bb_sample),
        .bb_strobe (bb_strobe),
        .frontend_i(frontend_i),
        .frontend_q(frontend_q)
    );

    dsp_tx_checker #(.WIDTH(WIDTH)) u_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .set_stb     (set_stb),
        .set_addr    (set_addr),
        .set_data    (set_data),
        .bb_sample   (bb_sample),
        .bb_strobe   (bb_strobe),
        .frontend_i  (frontend_i),
        .frontend_q  (frontend_q),
        .test_num    (test_num),
        .test_done   (test_done),
        .error_count (error_count),
        .tests_run   (tests_run),
        .tests_failed(tests_failed)
    );

    function automatic row_t make_row(input logic wr, input interp_rate_t rate, input gain_t gain,
                                      input rot_t rot, input logic [7:0] n, input logic corner,
                                      input logic [7:0] pause_at, input logic junk);
        return '{wr, rate, gain, rot, n, corner, pause_at, junk};
    endfunction

    task automatic load_table();
        // cfg, rate, gain, rot, samples, corner, pause at, junk write
        rows[0]  = make_row(1'b0, 8'd1, `CUSTOM_GAIN_UNITY, 2'd0, 8'd12, 1'b0, NO_PAUSE, 1'b0);
        rows[1]  = make_row(1'b1, 8'd1, `CUSTOM_GAIN_UNITY, 2'd0, 8'd10, 1'b0, NO_PAUSE, 1'b0);
        rows[2]  = make_row(1'b1, 8'd3, `CUSTOM_GAIN_UNITY, 2'd0, 8'd10, 1'b0, NO_PAUSE, 1'b0);
        rows[3]  = make_row(1'b1, 8'd8, `CUSTOM_GAIN_UNITY, 2'd0, 8'd8, 1'b0, NO_PAUSE, 1'b0);
        // 0.5, 1.75 and 3.99 in Q2.14
        rows[4]  = make_row(1'b1, 8'd2, 16'd8192, 2'd0, 8'd12, 1'b1, NO_PAUSE, 1'b0);
        rows[5]  = make_row(1'b1, 8'd1, 16'd28672, 2'd0, 8'd12, 1'b1, NO_PAUSE, 1'b0);
        rows[6]  = make_row(1'b1, 8'd1, 16'd65372, 2'd0, 8'd12, 1'b0, NO_PAUSE, 1'b0);
        rows[7]  = make_row(1'b1, 8'd1, `CUSTOM_GAIN_UNITY, 2'd1, 8'd12, 1'b1, NO_PAUSE, 1'b0);
        rows[8]  = make_row(1'b1, 8'd2, `CUSTOM_GAIN_UNITY, 2'd2, 8'd12, 1'b0, NO_PAUSE, 1'b0);
        rows[9]  = make_row(1'b1, 8'd3, `CUSTOM_GAIN_UNITY, 2'd3, 8'd12, 1'b1, NO_PAUSE, 1'b0);
        // enable dropped partway through
        rows[10] = make_row(1'b1, 8'd4, 16'd28672, 2'd1, 8'd10, 1'b0, 8'd4, 1'b0);
        rows[11] = make_row(1'b1, 8'd1, `CUSTOM_GAIN_UNITY, 2'd0, 8'd10, 1'b0, 8'd5, 1'b0);
        rows[12] = make_row(1'b1, 8'd5, `CUSTOM_GAIN_UNITY, 2'd2, 8'd8, 1'b0, NO_PAUSE, 1'b1);
        // rate 0 runs as rate 1
        rows[13] = make_row(1'b1, 8'd0, `CUSTOM_GAIN_UNITY, 2'd0, 8'd8, 1'b0, NO_PAUSE, 1'b0);
    endtask

    // full scale, one off full scale, the negation corner and small values
    function automatic iq_comp_t corner_value(input int k);
        case (k % 6)
            0: return 16'sh7FFF;
            1: return 16'sh8001;
            2: return 16'sh8000;
            3: return 16'sh0000;
            4: return 16'sh0001;
            default: return 16'shFFFF;
        endcase
    endfunction

    task automatic write_setting(input set_addr_t addr, input set_data_t data);
        set_stb  = 1'b1;
        set_addr = addr;
        set_data = data;
        @(negedge clock);
        set_stb  = 1'b0;
    endtask

    // hold the sample until a strobe cycle takes it, return on the next falling edge
    task automatic serve_sample(input sample_t s);
        bb_sample = s;
        while (!bb_strobe) begin
            @(negedge clock);
        end
        @(negedge clock);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   k;
        r = rows[idx];
        enable = 1'b0;
        @(negedge clock);
        if (r.write_cfg) begin
            write_setting(`SR_DUC_RATE, {24'd0, r.rate});
            write_setting(`SR_CUSTOM_GAIN, {16'd0, r.gain});
            write_setting(`SR_DUC_ROT, {30'd0, r.rot});
        end
        if (r.junk) begin
            write_setting(8'd3, $urandom());
            write_setting(8'hA5, $urandom());
        end
        test_num = 8'(idx);
        enable = 1'b1;
        for (k = 0; k < int'(r.nsamp); k++) begin
            if (k == int'(r.pause_at)) begin
                enable = 1'b0;
                repeat (3) @(negedge clock);
                enable = 1'b1;
            end
            if (r.corner) begin
                serve_sample({corner_value(k), corner_value(k + 3)});
            end else begin
                serve_sample(sample_t'($urandom()));
            end
        end
        // let the last value sit for a full hold with enable low
        enable = 1'b0;
        repeat (int'(r.rate) + 2) @(negedge clock);
        test_done = 1'b1;
        @(negedge clock);
        test_done = 1'b0;
    endtask

    initial begin : watchdog
        longint limit;
        int     i;
        wait (table_ready);
        limit = RESET_CYCLES;
        for (i = 0; i < NUM_ROWS; i++) begin
            limit += longint'(rows[i].nsamp) * ((rows[i].rate == 0) ? 1 : rows[i].rate);
            limit += ROW_SETUP;
        end
        limit = limit * 2;
        #(limit * PERIOD);
        $display("timeout: the run did not finish within %0d clock periods", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        int i;
        rst_n     = 1'b0;
        enable    = 1'b0;
        set_stb   = 1'b0;
        set_addr  = '0;
        set_data  = '0;
        bb_sample = '0;
        test_num  = '0;
        test_done = 1'b0;
        void'($urandom(SEED));
        load_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        repeat (2) @(negedge clock);
        assert_fails = u_dsp_tx_core.u_dsp_tx_assert.fail_count;
        $display("summary: %0d of %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, NUM_ROWS, tests_failed, error_count, assert_fails);
        if (tests_run == NUM_ROWS && tests_failed == 0 && error_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dsp_tx_core.f
+incdir+include
verilog/dsp_tx_pkg.sv
verilog/custom_dsp_tx.sv
verilog/duc_chain.sv
verilog/dsp_tx_core.sv
testbench/dsp_tx_checker.sv
testbench/dsp_tx_assert.sv
testbench/dsp_tx_core_tb.sv

//--- Bender.yml
package:
  name: dsp_tx_core

export_include_dirs:
  - include

sources:
  - files:
      - verilog/dsp_tx_pkg.sv
      - verilog/custom_dsp_tx.sv
      - verilog/duc_chain.sv
      - verilog/dsp_tx_core.sv
  - target: test
    files:
      - testbench/dsp_tx_checker.sv
      - testbench/dsp_tx_assert.sv
      - testbench/dsp_tx_core_tb.sv
